/* design/preg_pkg.sv */
`include "rob_defs.svh"

package preg_pkg;

    typedef logic [`PREG_W-1:0] preg_t;    // physical register number
    typedef logic [`XLEN-1:0]   xdata_t;   // one register value

    // one retired instruction as seen by the architectural state
    typedef struct packed {
        logic             we;              // low for stores
        preg_t            pdest;
        preg_t            old_pdest;       // freed when we is set
        xdata_t           data;
        logic [`XLEN-1:0] pc;
    } commit_t;

endpackage

/* design/preg_ready_table.sv */
`include "rob_defs.svh"

module preg_ready_table
    import preg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   alloc_valid,
    input  preg_t                  alloc_preg,
    input  logic [`CMPL_PORTS-1:0] set_valid,
    input  preg_t                  set_preg [`CMPL_PORTS],
    input  xdata_t                 set_data [`CMPL_PORTS],
    output logic [`PREG_NUM-1:0]   ready_vec,
    output logic [`CMPL_PORTS-1:0] wakeup_valid,
    output preg_t                  wakeup_preg [`CMPL_PORTS],
    output xdata_t                 wakeup_data [`CMPL_PORTS]
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ready_vec    <= '1;   // all registers hold values out of reset
            wakeup_valid <= '0;
        end else begin
            if (alloc_valid) begin
                ready_vec[alloc_preg] <= 1'b0;   // new dest not produced yet
            end
            // applied after the clear, so a same cycle completion wins
            for (int p = 0; p < `CMPL_PORTS; p++) begin
                if (set_valid[p]) begin
                    ready_vec[set_preg[p]] <= 1'b1;
                end
            end
            wakeup_valid <= set_valid;
        end
    end

    // broadcast to the issue queue, qualified by wakeup_valid
    always_ff @(posedge clk) begin
        wakeup_preg <= set_preg;
        wakeup_data <= set_data;
    end

endmodule

/* design/rob_cmpl_if.sv */
`include "rob_defs.svh"

interface rob_cmpl_if
    import preg_pkg::*;
    import rob_entry_pkg::*;
();

    logic [`CMPL_PORTS-1:0] valid;              // one bit per functional unit
    rob_tag_t               tag  [`CMPL_PORTS];
    xdata_t                 data [`CMPL_PORTS];

    // functional unit side
    modport src (output valid, output tag, output data);

    // entry storage side
    modport sink (input valid, input tag, input data);

endinterface

/* design/rob_entry_pkg.sv */
`include "rob_defs.svh"

package rob_entry_pkg;

    import preg_pkg::*;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;  // entry index

    // what rename hands over on dispatch
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        preg_t            pdest;
        preg_t            old_pdest;
        logic             is_store;
    } disp_req_t;

    // full view of one entry, as shown at the head
    typedef struct packed {
        logic             valid;
        logic             done;
        logic             is_store;
        logic [`XLEN-1:0] pc;
        preg_t            pdest;
        preg_t            old_pdest;
        xdata_t           result;
    } rob_entry_t;

endpackage

/* design/rob_head_if.sv */
`include "rob_defs.svh"

interface rob_head_if
    import rob_entry_pkg::*;
();

    // oldest entries, slot 0 is the head itself
    rob_entry_t head_entry [`RETIRE_W];

    // how many head entries leave this cycle, 0 to 2
    logic [1:0] release_cnt;

    modport store (
        output head_entry,
        input  release_cnt
    );

    modport retire (
        input  head_entry,
        output release_cnt
    );

endinterface

/* design/rob_retire.sv */
`include "rob_defs.svh"

module rob_retire
    import preg_pkg::*;
    import rob_entry_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    rob_head_if.retire           head,
    output logic [`RETIRE_W-1:0] commit_valid,
    output commit_t              commit [`RETIRE_W],
    output logic [1:0]           credit_return
);

    logic [`RETIRE_W-1:0] fire;   // slot retires this cycle

    // a slot retires only behind a retiring older slot
    always_comb begin
        logic       in_order;
        logic [1:0] cnt;
        in_order = 1'b1;
        cnt      = '0;
        for (int i = 0; i < `RETIRE_W; i++) begin
            fire[i]  = in_order && head.head_entry[i].valid && head.head_entry[i].done;
            in_order = fire[i];
            cnt      = cnt + fire[i];
        end
        head.release_cnt = cnt;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            commit_valid  <= '0;
            credit_return <= '0;
        end else begin
            commit_valid  <= fire;
            credit_return <= head.release_cnt;   // one credit per freed entry
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RETIRE_W; i++) begin
            if (fire[i]) begin
                commit[i] <= '{
                    we:        !head.head_entry[i].is_store,  // stores write nothing
                    pdest:     head.head_entry[i].pdest,
                    old_pdest: head.head_entry[i].old_pdest,
                    data:      head.head_entry[i].result,
                    pc:        head.head_entry[i].pc
                };
            end
        end
    end

endmodule

/* design/rob_storage.sv */
`include "rob_defs.svh"

module rob_storage
    import preg_pkg::*;
    import rob_entry_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      disp_valid,
    input  disp_req_t disp_req,
    output rob_tag_t  disp_tag,
    output preg_t     cmpl_pdest [`CMPL_PORTS],
    rob_cmpl_if.sink  cmpl,
    rob_head_if.store head
);

    logic [`ROB_DEPTH-1:0] valid_q;
    logic [`ROB_DEPTH-1:0] done_q;
    disp_req_t             info_q   [`ROB_DEPTH];  // pc and register fields
    xdata_t                result_q [`ROB_DEPTH];
    rob_tag_t              head_ptr;
    rob_tag_t              tail_ptr;
    rob_tag_t              slot_ptr [`RETIRE_W];

    assign disp_tag = tail_ptr;   // next free slot, credits keep it free

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q  <= '0;
            done_q   <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            // release retired head entries
            for (int i = 0; i < `RETIRE_W; i++) begin
                if (i < head.release_cnt) begin
                    valid_q[slot_ptr[i]] <= 1'b0;
                end
            end
            head_ptr <= head_ptr + rob_tag_t'(head.release_cnt);

            if (disp_valid) begin
                valid_q[tail_ptr] <= 1'b1;
                done_q[tail_ptr]  <= 1'b0;
                tail_ptr          <= tail_ptr + 1'b1;  // wraps at depth
            end

            for (int p = 0; p < `CMPL_PORTS; p++) begin
                if (cmpl.valid[p]) begin
                    done_q[cmpl.tag[p]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid) begin
            info_q[tail_ptr] <= disp_req;
        end
        for (int p = 0; p < `CMPL_PORTS; p++) begin
            if (cmpl.valid[p]) begin
                result_q[cmpl.tag[p]] <= cmpl.data[p];
            end
        end
    end

    // head and the entry after it, read combinationally
    always_comb begin
        for (int i = 0; i < `RETIRE_W; i++) begin
            slot_ptr[i] = head_ptr + rob_tag_t'(i);
            head.head_entry[i] = '{
                valid:     valid_q[slot_ptr[i]],
                done:      done_q[slot_ptr[i]],
                is_store:  info_q[slot_ptr[i]].is_store,
                pc:        info_q[slot_ptr[i]].pc,
                pdest:     info_q[slot_ptr[i]].pdest,
                old_pdest: info_q[slot_ptr[i]].old_pdest,
                result:    result_q[slot_ptr[i]]
            };
        end
    end

    // destination of each completing entry, for the ready table
    always_comb begin
        for (int p = 0; p < `CMPL_PORTS; p++) begin
            cmpl_pdest[p] = info_q[cmpl.tag[p]].pdest;
        end
    end

endmodule

/* design/rob_top.sv */
`include "rob_defs.svh"

module rob_top
    import preg_pkg::*;
    import rob_entry_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   disp_valid,
    input  logic [`XLEN-1:0]       disp_pc,
    input  logic [`PREG_W-1:0]     disp_pdest,
    input  logic [`PREG_W-1:0]     disp_old_pdest,
    input  logic                   disp_is_store,
    input  logic [`CMPL_PORTS-1:0] cmpl_valid,
    input  logic [`ROB_TAG_W-1:0]  cmpl_tag  [`CMPL_PORTS],
    input  logic [`XLEN-1:0]       cmpl_data [`CMPL_PORTS],
    output logic [`ROB_TAG_W-1:0]  disp_tag,
    output logic [1:0]             credit_return,
    output logic [`RETIRE_W-1:0]   commit_valid,
    output logic [`RETIRE_W-1:0]   commit_we,
    output logic [`PREG_W-1:0]     commit_pdest     [`RETIRE_W],
    output logic [`PREG_W-1:0]     commit_old_pdest [`RETIRE_W],
    output logic [`XLEN-1:0]       commit_data      [`RETIRE_W],
    output logic [`XLEN-1:0]       commit_pc        [`RETIRE_W],
    output logic [`PREG_NUM-1:0]   preg_ready,
    output logic [`CMPL_PORTS-1:0] wakeup_valid,
    output logic [`PREG_W-1:0]     wakeup_preg [`CMPL_PORTS],
    output logic [`XLEN-1:0]       wakeup_data [`CMPL_PORTS]
);

    rob_cmpl_if cmpl_bus ();
    rob_head_if head_bus ();

    disp_req_t disp_req;
    preg_t     cmpl_pdest [`CMPL_PORTS];
    commit_t   commit     [`RETIRE_W];

    assign disp_req = '{
        pc:        disp_pc,
        pdest:     disp_pdest,
        old_pdest: disp_old_pdest,
        is_store:  disp_is_store
    };

    // functional unit reports onto the completion bus
    assign cmpl_bus.valid = cmpl_valid;
    assign cmpl_bus.tag   = cmpl_tag;
    assign cmpl_bus.data  = cmpl_data;

    rob_storage u_storage (
        .clk        (clk),
        .rstn       (rstn),
        .disp_valid (disp_valid),
        .disp_req   (disp_req),
        .disp_tag   (disp_tag),
        .cmpl_pdest (cmpl_pdest),
        .cmpl       (cmpl_bus.sink),
        .head       (head_bus.store)
    );

    preg_ready_table u_ready (
        .clk          (clk),
        .rstn         (rstn),
        .alloc_valid  (disp_valid),
        .alloc_preg   (disp_pdest),
        .set_valid    (cmpl_valid),
        .set_preg     (cmpl_pdest),
        .set_data     (cmpl_data),
        .ready_vec    (preg_ready),
        .wakeup_valid (wakeup_valid),
        .wakeup_preg  (wakeup_preg),
        .wakeup_data  (wakeup_data)
    );

    rob_retire u_retire (
        .clk           (clk),
        .rstn          (rstn),
        .head          (head_bus.retire),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .credit_return (credit_return)
    );

    // flatten commit structs onto plain ports
    for (genvar i = 0; i < `RETIRE_W; i++) begin : g_commit
        assign commit_we[i]        = commit[i].we;
        assign commit_pdest[i]     = commit[i].pdest;
        assign commit_old_pdest[i] = commit[i].old_pdest;
        assign commit_data[i]      = commit[i].data;
        assign commit_pc[i]        = commit[i].pc;
    end

endmodule

/* include/rob_defs.svh */
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// reorder buffer sizing
`define ROB_DEPTH   16
`define ROB_TAG_W   4

// physical register file
`define PREG_NUM    64
`define PREG_W      6

// datapath width
`define XLEN        32

// functional unit completion ports and retire width
`define CMPL_PORTS  4
`define RETIRE_W    2

`endif

/* rob_subsys.f */
+incdir+include
design/preg_pkg.sv
design/rob_entry_pkg.sv
design/rob_cmpl_if.sv
design/rob_head_if.sv
design/rob_storage.sv
design/preg_ready_table.sv
design/rob_retire.sv
design/rob_top.sv
tests/rob_checker.sv
tests/rob_tb.sv

/* tests/rob_checker.sv */
`include "rob_defs.svh"

module rob_checker (
    input logic                 clk,
    input logic                 rstn,
    input logic                 disp_valid,
    input logic [1:0]           credit_return,
    input logic [`RETIRE_W-1:0] commit_valid
);

    logic [5:0] credits;   // rename side view that starts full

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credits <= `ROB_DEPTH;
        end else begin
            credits <= credits + credit_return - disp_valid;
        end
    end

    // a credit returned in this cycle is already usable
    a_credit_held: assert property (@(posedge clk) disable iff (!rstn)
        disp_valid |-> (credits + credit_return) != 0)
        else $error("dispatch with no credit left");

    // one credit per retired entry
    a_credit_count: assert property (@(posedge clk) disable iff (!rstn)
        credit_return == {1'b0, commit_valid[0]} + {1'b0, commit_valid[1]})
        else $error("credit_return differs from commit count");

    a_commit_order: assert property (@(posedge clk) disable iff (!rstn)
        commit_valid[1] |-> commit_valid[0])
        else $error("younger slot committed without the head");

endmodule

bind rob_top rob_checker u_checker (
    .clk           (clk),
    .rstn          (rstn),
    .disp_valid    (disp_valid),
    .credit_return (credit_return),
    .commit_valid  (commit_valid)
);

/* tests/rob_tb.sv */
`include "rob_defs.svh"

module rob_tb;

    localparam int LINES  = 22;
    localparam int FILL_N = 16;   // lines that fill the rob

    logic                   clk;
    logic                   rstn;
    logic                   disp_valid;
    logic [`XLEN-1:0]       disp_pc;
    logic [`PREG_W-1:0]     disp_pdest;
    logic [`PREG_W-1:0]     disp_old_pdest;
    logic                   disp_is_store;
    logic [`CMPL_PORTS-1:0] cmpl_valid;
    logic [`ROB_TAG_W-1:0]  cmpl_tag  [`CMPL_PORTS];
    logic [`XLEN-1:0]       cmpl_data [`CMPL_PORTS];
    logic [`ROB_TAG_W-1:0]  disp_tag;
    logic [1:0]             credit_return;
    logic [`RETIRE_W-1:0]   commit_valid;
    logic [`RETIRE_W-1:0]   commit_we;
    logic [`PREG_W-1:0]     commit_pdest     [`RETIRE_W];
    logic [`PREG_W-1:0]     commit_old_pdest [`RETIRE_W];
    logic [`XLEN-1:0]       commit_data      [`RETIRE_W];
    logic [`XLEN-1:0]       commit_pc        [`RETIRE_W];
    logic [`PREG_NUM-1:0]   preg_ready;
    logic [`CMPL_PORTS-1:0] wakeup_valid;
    logic [`PREG_W-1:0]     wakeup_preg [`CMPL_PORTS];
    logic [`XLEN-1:0]       wakeup_data [`CMPL_PORTS];

    logic [63:0]            stim [LINES];   // one instruction per line
    logic [`PREG_NUM-1:0]   ref_ready;
    logic [`CMPL_PORTS-1:0] last_valid;     // completions driven last cycle
    logic [`PREG_W-1:0]     last_preg [`CMPL_PORTS];
    logic [`XLEN-1:0]       last_data [`CMPL_PORTS];
    int                     cmpl_cycle [LINES];
    bit                     lat_check  [LINES];
    int                     credits;
    int                     disp_cnt;
    int                     commit_ptr;
    int                     cycle;
    int                     error_cnt;
    integer                 seed;

    rob_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [`XLEN-1:0] result_for_pc(input logic [`XLEN-1:0] pc);
        return {pc[15:0], pc[15:0] ^ 16'hc3a5};
    endfunction

    task automatic stop_run(input string reason);
        error_cnt++;
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic expect_equal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got === exp) else stop_run($sformatf("Fail %s: got %h expected %h",
                                                     name, got, exp));
    endtask

    // oldest outstanding instruction against a commit slot
    task automatic check_commit(input int i);
        logic [63:0] s;
        if (commit_ptr >= disp_cnt) stop_run("commit seen with nothing outstanding");
        s = stim[commit_ptr];
        expect_equal($sformatf("commit_pc[%0d]", i), commit_pc[i], s[63:32]);
        expect_equal($sformatf("commit_pdest[%0d]", i), commit_pdest[i], s[29:24]);
        expect_equal($sformatf("commit_old_pdest[%0d]", i), commit_old_pdest[i], s[21:16]);
        expect_equal($sformatf("commit_we[%0d]", i), commit_we[i], s[8]);
        expect_equal($sformatf("commit_data[%0d]", i), commit_data[i],
                     result_for_pc(s[63:32]));
        if (lat_check[commit_ptr]) begin
            assert (cycle == cmpl_cycle[commit_ptr] + 2)
                else stop_run("commit latency after completion is not two cycles");
        end
        commit_ptr++;
    endtask

    task automatic check_outputs();
        int n;
        n = 0;
        expect_equal("preg_ready", preg_ready, ref_ready);
        assert (commit_valid[0] || !commit_valid[1])
            else stop_run("second commit slot fired without the first");
        for (int i = 0; i < `RETIRE_W; i++) begin
            if (commit_valid[i]) begin
                check_commit(i);
                n++;
            end
        end
        expect_equal("credit_return", credit_return, n);
        credits = credits + n;
        expect_equal("wakeup_valid", wakeup_valid, last_valid);
        for (int p = 0; p < `CMPL_PORTS; p++) begin
            if (last_valid[p]) begin
                expect_equal($sformatf("wakeup_preg[%0d]", p), wakeup_preg[p], last_preg[p]);
                expect_equal($sformatf("wakeup_data[%0d]", p), wakeup_data[p], last_data[p]);
            end
        end
    endtask

    // check what the last edge produced and idle the inputs
    task automatic step();
        @(negedge clk);
        cycle++;
        check_outputs();
        disp_valid = 1'b0;
        cmpl_valid = '0;
        last_valid = '0;
    endtask

    task automatic dispatch_line(input int l);
        assert (credits > 0) else stop_run("dispatch attempted with no credit left");
        expect_equal("disp_tag", disp_tag, disp_cnt % `ROB_DEPTH);
        disp_valid     = 1'b1;
        disp_pc        = stim[l][63:32];
        disp_pdest     = stim[l][29:24];
        disp_old_pdest = stim[l][21:16];
        disp_is_store  = stim[l][12];
        ref_ready[stim[l][29:24]] = 1'b0;
        credits--;
        disp_cnt++;
    endtask

    task automatic complete_seq(input int p, input int s);
        cmpl_valid[p] = 1'b1;
        cmpl_tag[p]   = s % `ROB_DEPTH;
        cmpl_data[p]  = result_for_pc(stim[s][63:32]);
        last_valid[p] = 1'b1;
        last_preg[p]  = stim[s][29:24];
        last_data[p]  = cmpl_data[p];
        ref_ready[stim[s][29:24]] = 1'b1;
        cmpl_cycle[s] = cycle;
        lat_check[s]  = (commit_ptr == s);   // all older already committed
    endtask

    task automatic wait_for_commits(input int limit);
        int waited;
        waited = 0;
        while (commit_ptr < disp_cnt) begin
            if (waited == limit) stop_run("timeout waiting for commits");
            step();
            waited++;
        end
    endtask

    initial begin
        int pending [$];
        int guard;
        int n;
        int k;
        seed           = 85854;
        rstn           = 1'b0;
        disp_valid     = 1'b0;
        disp_pc        = '0;
        disp_pdest     = '0;
        disp_old_pdest = '0;
        disp_is_store  = 1'b0;
        cmpl_valid     = '0;
        for (int p = 0; p < `CMPL_PORTS; p++) begin
            cmpl_tag[p]  = '0;
            cmpl_data[p] = '0;
        end
        ref_ready  = '1;
        last_valid = '0;
        credits    = `ROB_DEPTH;
        disp_cnt   = 0;
        commit_ptr = 0;
        cycle      = 0;
        error_cnt  = 0;
        $readmemh("tests/rob_testdata.txt", stim);

        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (3) step();   // idle, nothing may commit

        // fill every entry back to back
        for (int l = 0; l < FILL_N; l++) begin
            step();
            dispatch_line(l);
            pending.push_back(l);
        end
        repeat (3) step();
        expect_equal("rename credits", credits, 0);

        // complete in shuffled order with up to four per cycle
        guard = 0;
        while (pending.size() > 0) begin
            if (guard == 40) stop_run("completion schedule did not finish");
            step();
            n = 1 + $unsigned($random(seed)) % `CMPL_PORTS;
            for (int p = 0; p < n && pending.size() > 0; p++) begin
                k = $unsigned($random(seed)) % pending.size();
                complete_seq(p, pending[k]);
                pending.delete(k);
            end
            guard++;
        end
        wait_for_commits(40);
        step();
        expect_equal("rename credits", credits, `ROB_DEPTH);

        // one at a time with completion after the listed delay
        for (int l = FILL_N; l < LINES; l++) begin
            step();
            dispatch_line(l);
            repeat (stim[l][7:0] + 1) step();
            complete_seq(l % `CMPL_PORTS, l);
            wait_for_commits(10);
        end
        repeat (2) step();
        expect_equal("rename credits", credits, `ROB_DEPTH);

        if (error_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tests/rob_testdata.txt */
// pc _ pdest _ old_pdest _ is_store _ expected we _ delay, all hex, one word per line
// lines 0 to 15 fill the rob with delay 0, the rest complete after their delay
00001000_10_20_0_1_00
00001004_11_21_0_1_00
00001008_12_22_0_1_00
0000100c_13_23_1_0_00
00001010_14_24_0_1_00
00001014_15_25_0_1_00
00001018_16_26_0_1_00
0000101c_17_27_0_1_00
00001020_18_28_0_1_00
00001024_19_29_1_0_00
00001028_1a_2a_0_1_00
0000102c_1b_2b_0_1_00
00001030_1c_2c_0_1_00
00001034_1d_2d_0_1_00
00001038_1e_2e_1_0_00
0000103c_1f_2f_0_1_00
00002000_30_10_0_1_00
00002004_31_11_0_1_02
00002008_32_12_0_1_05
0000200c_33_13_1_0_01
00002010_34_30_0_1_03
00002014_35_31_0_1_00
